// File: verilog/music_pkg.sv
`default_nettype none

package music_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    // four songs
    localparam int song_width = 2;
    // sixteen entries per song
    localparam int entry_width = 4;
    localparam int note_width = 6;
    localparam int duration_width = 6;
    // song index on top, entry index below
    localparam int rom_addr_width = song_width + entry_width;
    localparam int rom_depth = 1 << rom_addr_width;

    // ------------------------------------------------------------------
    // timing and voice count
    // ------------------------------------------------------------------
    // clocks per beat, kept small for short runs
    localparam int beat_cycles = 4;
    localparam int beat_count_width = $clog2(beat_cycles);
    localparam int num_voices = 3;

    // reader fsm encoding
    typedef enum logic [2:0] {
        paused            = 3'd0,
        retrieve_note     = 3'd1,
        decode            = 3'd2,
        new_note_ready    = 3'd3,
        advance_time      = 3'd4,
        increment_address = 3'd5
    } reader_state_e;

    // ------------------------------------------------------------------
    // rom word layouts
    // ------------------------------------------------------------------
    // note event, top bit clear
    typedef struct packed {
        logic                      is_advance;
        logic [note_width-1:0]     note;
        logic [duration_width-1:0] duration;
        logic [2:0]                pad;
    } note_event_t;

    // advance event, top bit set
    typedef struct packed {
        logic                      is_advance;
        logic [duration_width-1:0] beats;
        logic [8:0]                pad;
    } advance_event_t;

    // one 16-bit word, two readings of it
    typedef union packed {
        note_event_t    note_ev;
        advance_event_t advance_ev;
    } rom_word_u;

endpackage

`default_nettype wire

// File: verilog/song_rom.sv
`default_nettype none

module song_rom (
    input  logic                                  clk,
    input  logic [music_pkg::rom_addr_width-1:0]  addr,
    output music_pkg::rom_word_u                  dout
);

    // four songs of sixteen words, song index in the upper address bits
    logic [$bits(music_pkg::rom_word_u)-1:0] mem [0:music_pkg::rom_depth-1];

    initial begin
        $readmemh("song_data.hex", mem);
    end

    // registered read
    // word shows up the cycle after the address is presented
    always_ff @(posedge clk) begin
        dout <= mem[addr];
    end

endmodule

`default_nettype wire

// File: verilog/time_advancer.sv
`default_nettype none

module time_advancer (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  load_duration,
    input  logic [music_pkg::duration_width-1:0]  duration,
    input  logic                                  beat,
    output logic                                  advance_done
);

    // beats still to wait
    logic [music_pkg::duration_width-1:0] count;
    // set between load and done
    logic active;
    // last beat of the wait, or any beat after a zero load
    logic last_beat;

    assign last_beat = beat && active && (count <= 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            count        <= '0;
            active       <= 1'b0;
            advance_done <= 1'b0;
        end else begin
            // single-cycle pulse
            advance_done <= 1'b0;
            if (load_duration) begin
                // load wins over a coincident beat
                count  <= duration;
                active <= 1'b1;
            end else if (last_beat) begin
                count        <= '0;
                active       <= 1'b0;
                advance_done <= 1'b1;
            end else if (beat && active) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/song_reader.sv
`default_nettype none

module song_reader (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  play,
    input  logic [music_pkg::song_width-1:0]      song,
    input  logic                                  beat,
    input  logic                                  busy_one,
    input  logic                                  busy_two,
    input  logic                                  busy_three,
    output logic [music_pkg::note_width-1:0]      note,
    output logic [music_pkg::duration_width-1:0]  duration,
    output logic                                  new_note_one,
    output logic                                  new_note_two,
    output logic                                  new_note_three,
    output logic                                  song_done
);

    music_pkg::reader_state_e state;
    music_pkg::reader_state_e next_state;

    // position within the selected song
    logic [music_pkg::entry_width-1:0] entry;
    logic [music_pkg::rom_addr_width-1:0] rom_addr;
    music_pkg::rom_word_u word;

    logic is_advance;
    logic last_entry;
    logic load_advancer;
    logic advance_done;
    // some voice can take a note
    logic voice_free;
    // issue strobe before voice selection
    logic issue;

    // ------------------------------------------------------------------
    // rom and advancer
    // ------------------------------------------------------------------
    assign rom_addr = {song, entry};

    song_rom rom (
        .clk  (clk),
        .addr (rom_addr),
        .dout (word)
    );

    // only advance words load the advancer, in decode
    assign load_advancer = (state == music_pkg::decode) && is_advance;

    time_advancer advance (
        .clk           (clk),
        .reset         (reset),
        .load_duration (load_advancer),
        .duration      (word.advance_ev.beats),
        .beat          (beat),
        .advance_done  (advance_done)
    );

    // ------------------------------------------------------------------
    // word decode
    // ------------------------------------------------------------------
    // top bit shared by both layouts
    assign is_advance = word.note_ev.is_advance;
    // note fields go out on the shared voice buses
    assign note       = word.note_ev.note;
    assign duration   = word.note_ev.duration;
    assign last_entry = (entry == {music_pkg::entry_width{1'b1}});

    // ------------------------------------------------------------------
    // voice allocation
    // ------------------------------------------------------------------
    assign voice_free = !(busy_one && busy_two && busy_three);
    assign issue = (state == music_pkg::new_note_ready) && play;

    // fixed priority, lowest free voice gets the note
    assign new_note_one   = issue && !busy_one;
    assign new_note_two   = issue && busy_one && !busy_two;
    assign new_note_three = issue && busy_one && busy_two && !busy_three;

    // end of song, one cycle in increment_address
    assign song_done = (state == music_pkg::increment_address) && last_entry;

    // ------------------------------------------------------------------
    // fsm
    // ------------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            music_pkg::paused: begin
                if (play) begin
                    next_state = music_pkg::retrieve_note;
                end
            end
            music_pkg::retrieve_note: begin
                // rom read in flight
                next_state = play ? music_pkg::decode : music_pkg::paused;
            end
            music_pkg::decode: begin
                if (!play) begin
                    next_state = music_pkg::paused;
                end else if (is_advance) begin
                    next_state = music_pkg::advance_time;
                end else begin
                    next_state = music_pkg::new_note_ready;
                end
            end
            music_pkg::new_note_ready: begin
                // wait here as long as every voice is busy
                if (!play) begin
                    next_state = music_pkg::paused;
                end else if (voice_free) begin
                    next_state = music_pkg::increment_address;
                end
            end
            music_pkg::advance_time: begin
                // finish the wait even if play drops
                if (advance_done) begin
                    next_state = music_pkg::increment_address;
                end
            end
            music_pkg::increment_address: begin
                if (last_entry || !play) begin
                    next_state = music_pkg::paused;
                end else begin
                    next_state = music_pkg::retrieve_note;
                end
            end
            default: begin
                next_state = music_pkg::paused;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= music_pkg::paused;
            entry <= '0;
        end else begin
            state <= next_state;
            // entry consumed, wraps to 0 after the last one
            if (state == music_pkg::increment_address) begin
                entry <= last_entry ? '0 : entry + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/note_voice.sv
`default_nettype none

module note_voice (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  beat,
    input  logic                                  new_note,
    input  logic [music_pkg::note_width-1:0]      note_in,
    input  logic [music_pkg::duration_width-1:0]  duration_in,
    output logic [music_pkg::note_width-1:0]      note,
    output logic [music_pkg::duration_width-1:0]  duration,
    output logic                                  busy
);

    // beats left on the current note
    logic [music_pkg::duration_width-1:0] remaining;

    // held note and its full duration
    always_ff @(posedge clk) begin
        if (new_note) begin
            note     <= note_in;
            duration <= duration_in;
        end
    end

    // ------------------------------------------------------------------
    // duration countdown
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            remaining <= '0;
            busy      <= 1'b0;
        end else if (new_note) begin
            // a beat in the same cycle is not counted
            remaining <= duration_in;
            busy      <= 1'b1;
        end else if (beat && busy) begin
            // zero or one left, this beat ends the note
            if (remaining <= 1) begin
                remaining <= '0;
                busy      <= 1'b0;
            end else begin
                remaining <= remaining - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/beat_generator.sv
`default_nettype none

module beat_generator (
    input  logic clk,
    input  logic reset,
    output logic beat
);

    logic [music_pkg::beat_count_width-1:0] count;
    logic wrap;

    // last clock of the beat period
    assign wrap = (count == music_pkg::beat_count_width'(music_pkg::beat_cycles - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            beat  <= 1'b0;
        end else begin
            count <= wrap ? '0 : count + 1'b1;
            // one-cycle pulse per period
            beat  <= wrap;
        end
    end

endmodule

`default_nettype wire

// File: verilog/music_core.sv
`default_nettype none

module music_core (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  play,
    input  logic [music_pkg::song_width-1:0]      song,
    output logic                                  beat,
    output logic                                  song_done,
    output logic [music_pkg::note_width-1:0]      note_one,
    output logic [music_pkg::note_width-1:0]      note_two,
    output logic [music_pkg::note_width-1:0]      note_three,
    output logic [music_pkg::duration_width-1:0]  duration_one,
    output logic [music_pkg::duration_width-1:0]  duration_two,
    output logic [music_pkg::duration_width-1:0]  duration_three,
    output logic                                  new_note_one,
    output logic                                  new_note_two,
    output logic                                  new_note_three,
    output logic                                  busy_one,
    output logic                                  busy_two,
    output logic                                  busy_three
);

    // shared note buses from the reader
    logic [music_pkg::note_width-1:0]     note_bus;
    logic [music_pkg::duration_width-1:0] duration_bus;
    // one busy bit per voice, voice one at bit 0
    logic [music_pkg::num_voices-1:0]     voice_busy;

    assign busy_one   = voice_busy[0];
    assign busy_two   = voice_busy[1];
    assign busy_three = voice_busy[2];

    beat_generator beat_gen (
        .clk   (clk),
        .reset (reset),
        .beat  (beat)
    );

    song_reader reader (
        .clk            (clk),
        .reset          (reset),
        .play           (play),
        .song           (song),
        .beat           (beat),
        .busy_one       (voice_busy[0]),
        .busy_two       (voice_busy[1]),
        .busy_three     (voice_busy[2]),
        .note           (note_bus),
        .duration       (duration_bus),
        .new_note_one   (new_note_one),
        .new_note_two   (new_note_two),
        .new_note_three (new_note_three),
        .song_done      (song_done)
    );

    // ------------------------------------------------------------------
    // voices
    // ------------------------------------------------------------------
    note_voice voice_one (
        .clk         (clk),
        .reset       (reset),
        .beat        (beat),
        .new_note    (new_note_one),
        .note_in     (note_bus),
        .duration_in (duration_bus),
        .note        (note_one),
        .duration    (duration_one),
        .busy        (voice_busy[0])
    );

    note_voice voice_two (
        .clk         (clk),
        .reset       (reset),
        .beat        (beat),
        .new_note    (new_note_two),
        .note_in     (note_bus),
        .duration_in (duration_bus),
        .note        (note_two),
        .duration    (duration_two),
        .busy        (voice_busy[1])
    );

    note_voice voice_three (
        .clk         (clk),
        .reset       (reset),
        .beat        (beat),
        .new_note    (new_note_three),
        .note_in     (note_bus),
        .duration_in (duration_bus),
        .note        (note_three),
        .duration    (duration_three),
        .busy        (voice_busy[2])
    );

endmodule

`default_nettype wire

// File: verification/music_core_asserts.sv
`default_nettype none

module music_core_asserts (
    input logic clk,
    input logic reset,
    input logic busy_one,
    input logic busy_two,
    input logic busy_three,
    input logic new_note_one,
    input logic new_note_two,
    input logic new_note_three,
    input logic song_done
);

    timeunit 1ns;
    timeprecision 1ps;

    // ------------------------------------------------------------------
    // voice allocation
    // ------------------------------------------------------------------
    // at most one voice picked per cycle
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({new_note_one, new_note_two, new_note_three}))
        else $error("more than one new_note in the same cycle");

    // a busy voice never gets a note
    assert property (@(posedge clk) disable iff (reset) new_note_one |-> !busy_one)
        else $error("note sent to voice one while busy");
    assert property (@(posedge clk) disable iff (reset) new_note_two |-> !busy_two)
        else $error("note sent to voice two while busy");
    assert property (@(posedge clk) disable iff (reset) new_note_three |-> !busy_three)
        else $error("note sent to voice three while busy");

    // end of song lasts one cycle
    assert property (@(posedge clk) disable iff (reset) song_done |=> !song_done)
        else $error("song_done held for more than one cycle");

endmodule

`default_nettype wire

// File: verification/music_core_tb.sv
`default_nettype none

module music_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int voices = music_pkg::num_voices;
    localparam int entries = 1 << music_pkg::entry_width;
    // longest possible song, every entry a 64 beat wait
    localparam int song_cycles = entries * 64 * music_pkg::beat_cycles;
    // four songs plus room for replays, pauses and idle time
    localparam int timeout_cycles = 4 * song_cycles + 8192;

    logic clk = 1'b0;
    logic reset;
    logic play;
    logic [music_pkg::song_width-1:0] song;
    logic beat;
    logic song_done;
    logic [music_pkg::note_width-1:0] note_one;
    logic [music_pkg::note_width-1:0] note_two;
    logic [music_pkg::note_width-1:0] note_three;
    logic [music_pkg::duration_width-1:0] duration_one;
    logic [music_pkg::duration_width-1:0] duration_two;
    logic [music_pkg::duration_width-1:0] duration_three;
    logic new_note_one;
    logic new_note_two;
    logic new_note_three;
    logic busy_one;
    logic busy_two;
    logic busy_three;

    // per-voice views of the outputs, voice one at index 0
    logic [voices-1:0] dut_busy;
    logic [voices-1:0] dut_new_note;
    logic [music_pkg::note_width-1:0] dut_note [voices];
    logic [music_pkg::duration_width-1:0] dut_dur [voices];

    // reference copy of the song rom
    logic [15:0] song_table [0:music_pkg::rom_depth-1];

    // ------------------------------------------------------------------
    // reference model state
    // ------------------------------------------------------------------
    logic [voices-1:0] model_busy;
    int model_left [voices];
    logic [music_pkg::note_width-1:0] model_note [voices];
    logic [music_pkg::duration_width-1:0] model_dur [voices];
    // next table entry the reader should reach
    int next_entry = 0;
    int beats_since_issue = 0;
    // clocks since reset released
    int beat_phase = 0;
    int song_done_count = 0;
    int value_errors = 0;
    int other_errors = 0;
    int cycle_count = 0;

    music_core i_music_core (
        .clk            (clk),
        .reset          (reset),
        .play           (play),
        .song           (song),
        .beat           (beat),
        .song_done      (song_done),
        .note_one       (note_one),
        .note_two       (note_two),
        .note_three     (note_three),
        .duration_one   (duration_one),
        .duration_two   (duration_two),
        .duration_three (duration_three),
        .new_note_one   (new_note_one),
        .new_note_two   (new_note_two),
        .new_note_three (new_note_three),
        .busy_one       (busy_one),
        .busy_two       (busy_two),
        .busy_three     (busy_three)
    );

    bind song_reader music_core_asserts asserts (
        .clk            (clk),
        .reset          (reset),
        .busy_one       (busy_one),
        .busy_two       (busy_two),
        .busy_three     (busy_three),
        .new_note_one   (new_note_one),
        .new_note_two   (new_note_two),
        .new_note_three (new_note_three),
        .song_done      (song_done)
    );

    assign dut_busy = {busy_three, busy_two, busy_one};
    assign dut_new_note = {new_note_three, new_note_two, new_note_one};
    assign dut_note[0] = note_one;
    assign dut_note[1] = note_two;
    assign dut_note[2] = note_three;
    assign dut_dur[0] = duration_one;
    assign dut_dur[1] = duration_two;
    assign dut_dur[2] = duration_three;

    always #5 clk = ~clk;

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    function automatic string voice_name(input int v);
        case (v)
            0: return "one";
            1: return "two";
            default: return "three";
        endcase
    endfunction

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_note(
        input string                                name,
        input logic [music_pkg::note_width-1:0]     got_note,
        input logic [music_pkg::duration_width-1:0] got_dur,
        input logic [music_pkg::note_width-1:0]     exp_note,
        input logic [music_pkg::duration_width-1:0] exp_dur
    );
        if (got_note !== exp_note || got_dur !== exp_dur) begin
            $display("FAILED %s: got note %h duration %h expected note %h duration %h",
                     name, got_note, got_dur, exp_note, exp_dur);
            value_errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR %s", msg);
        other_errors++;
    endtask

    // ------------------------------------------------------------------
    // monitor, samples mid cycle
    // ------------------------------------------------------------------
    always @(negedge clk) begin : monitor
        music_pkg::rom_word_u w;
        int v;
        int i;
        int exp_voice;
        int required;
        int found;
        if (reset) begin
            model_busy = '0;
            next_entry = 0;
            beats_since_issue = 0;
            beat_phase = 0;
        end else begin
            // one beat pulse every beat_cycles clocks
            beat_phase++;
            check_flag("beat", beat,
                       beat_phase > 1 && beat_phase % music_pkg::beat_cycles == 1);
            // held voice state against the model
            for (v = 0; v < voices; v++) begin
                check_flag({"busy_", voice_name(v)}, dut_busy[v], model_busy[v]);
                if (model_busy[v]) begin
                    check_note({"voice_", voice_name(v)}, dut_note[v], dut_dur[v],
                               model_note[v], model_dur[v]);
                end
            end
            exp_voice = -1;
            if (dut_new_note != '0) begin
                // issues stop while play is low
                if (!play) begin
                    report_problem("new_note issued while play was low");
                end
                // lowest free voice
                for (v = voices - 1; v >= 0; v--) begin
                    if (!model_busy[v]) begin
                        exp_voice = v;
                    end
                end
                if (exp_voice < 0) begin
                    report_problem("new_note issued while every voice was busy");
                end else begin
                    for (v = 0; v < voices; v++) begin
                        check_flag({"new_note_", voice_name(v)}, dut_new_note[v],
                                   v == exp_voice);
                    end
                end
                // walk the table to the next note, summing the waits
                required = 0;
                found = -1;
                for (i = next_entry; i < entries && found < 0; i++) begin
                    w = song_table[int'(song) * entries + i];
                    if (w.advance_ev.is_advance) begin
                        required += int'(w.advance_ev.beats);
                    end else begin
                        found = i;
                    end
                end
                if (found < 0) begin
                    report_problem($sformatf("note issued past the end of song %0d",
                                             int'(song)));
                end else if (beats_since_issue < required) begin
                    report_problem($sformatf(
                        "entry %0d issued %0d beats after the last one, %0d needed",
                        found, beats_since_issue, required));
                end
                if (found >= 0) begin
                    next_entry = found + 1;
                end
                beats_since_issue = 0;
            end else if (beat) begin
                beats_since_issue++;
            end
            // duration countdown, a zero duration still takes one beat
            for (v = 0; v < voices; v++) begin
                if (beat && model_busy[v]) begin
                    if (model_left[v] <= 1) begin
                        model_left[v] = 0;
                        model_busy[v] = 1'b0;
                    end else begin
                        model_left[v]--;
                    end
                end
            end
            if (exp_voice >= 0 && found >= 0) begin
                w = song_table[int'(song) * entries + found];
                model_note[exp_voice] = w.note_ev.note;
                model_dur[exp_voice] = w.note_ev.duration;
                model_left[exp_voice] = int'(w.note_ev.duration);
                model_busy[exp_voice] = 1'b1;
            end
            if (song_done) begin
                song_done_count++;
                for (i = next_entry; i < entries; i++) begin
                    w = song_table[int'(song) * entries + i];
                    if (!w.note_ev.is_advance) begin
                        report_problem($sformatf("song_done before entry %0d was issued", i));
                    end
                end
                next_entry = 0;
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("timeout, run still going after %0d cycles", timeout_cycles);
            $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    // play low, nothing may move
    task automatic check_idle(input int beats);
        int seen;
        int v;
        seen = 0;
        play = 1'b0;
        while (seen < beats) begin
            @(negedge clk);
            for (v = 0; v < voices; v++) begin
                check_flag({"new_note_", voice_name(v)}, dut_new_note[v], 1'b0);
                check_flag({"busy_", voice_name(v)}, dut_busy[v], 1'b0);
            end
            check_flag("song_done", song_done, 1'b0);
            if (beat) begin
                seen++;
            end
        end
    endtask

    // one full song, optionally dropping play at random points
    task automatic play_song(input int s, input bit with_pauses);
        int start_count;
        int run;
        int i;
        start_count = song_done_count;
        @(posedge clk);
        #1;
        song = music_pkg::song_width'(s);
        play = 1'b1;
        while (song_done_count == start_count) begin
            run = with_pauses ? 20 + int'($urandom % 60) : 1;
            i = 0;
            while (i < run && song_done_count == start_count) begin
                @(posedge clk);
                #1;
                i++;
            end
            if (with_pauses && song_done_count == start_count) begin
                play = 1'b0;
                run = 4 + int'($urandom % 30);
                i = 0;
                while (i < run && song_done_count == start_count) begin
                    @(posedge clk);
                    #1;
                    i++;
                end
                // an advance can finish the song while paused
                if (song_done_count == start_count) begin
                    play = 1'b1;
                end
            end
        end
        play = 1'b0;
        // quiet stretch, one pulse per song only
        repeat (8 * music_pkg::beat_cycles) @(posedge clk);
        if (song_done_count != start_count + 1) begin
            report_problem($sformatf("song %0d gave %0d song_done pulses", s,
                                     song_done_count - start_count));
        end
    endtask

    initial begin
        int s;
        void'($urandom(32'h2ff1));
        $readmemh("song_data.hex", song_table);
        reset = 1'b1;
        play = 1'b0;
        song = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_flag("beat", beat, 1'b0);
        check_idle(50);
        // song 0 straight, then again with pauses from entry 0
        play_song(0, 1'b0);
        play_song(0, 1'b1);
        for (s = 1; s < 4; s++) begin
            play_song(s, 1'b0);
        end
        play_song(1, 1'b1);
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: song_data.hex
// one 16-bit word per line, four songs of sixteen entries
// bit 15 clear: note[14:9] duration[8:3]; bit 15 set: beats[14:9]
3020
3818
3E10
4808
8400
4200
4628
8600
5010
4C30
5618
5A10
8000
5E08
8800
6018
1810
8200
1C10
8200
2020
2620
2A20
2E08
8400
3410
0018
8200
7E08
6410
6800
8600
8600
3C1D
4018
4418
4A18
4E18
85FF
5408
8000
8200
5810
5C10
6220
6620
6A20
6E10
7840
7238
6E30
8A00
6850
6018
5A10
5208
8C00
4820
4220
3A20
31F8
3410
8400
3E28

// File: tb.f
verilog/music_pkg.sv
verilog/song_rom.sv
verilog/time_advancer.sv
verilog/song_reader.sv
verilog/note_voice.sv
verilog/beat_generator.sv
verilog/music_core.sv
verification/music_core_asserts.sv
verification/music_core_tb.sv

// File: Makefile
# Verilator build and run of the music core testbench

VERILATOR ?= verilator
TOP       ?= music_core_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= TESTS PASSED

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# status follows the pass line in the simulator output
run: $(SIM) song_data.hex
	@out="$$($(SIM) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
